// File: hw/fetch_consts.svh
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

// ---------------------------------------------------------------------------
// Address and line geometry
// ---------------------------------------------------------------------------
`define FETCH_PADDR_WIDTH    32
`define FETCH_LINE_BYTES     16
`define FETCH_OFFSET_BITS    $clog2(`FETCH_LINE_BYTES)

// L2 grant channel
`define FETCH_BEAT_WIDTH     32
`define FETCH_BEATS_PER_LINE 4

// Direct-mapped instruction cache
`define ICACHE_NUM_SETS      32
`define ICACHE_IDX_BITS      $clog2(`ICACHE_NUM_SETS)

// Boot ROM window matched on the upper address bits
`define BROM_WINDOW_BITS     16
`define BROM_WINDOW_HI       16'h0001

`endif

// File: hw/fetch_pkg.sv
`include "fetch_consts.svh"

package fetch_pkg;

    // -----------------------------------------------------------------------
    // Address and data widths
    // -----------------------------------------------------------------------
    typedef logic [`FETCH_PADDR_WIDTH-1:0] paddr_t;
    typedef logic [`FETCH_PADDR_WIDTH-`FETCH_OFFSET_BITS-1:0] line_addr_t;  // No byte offset

    typedef logic [`ICACHE_IDX_BITS-1:0] icache_idx_t;
    typedef logic [`FETCH_PADDR_WIDTH-`FETCH_OFFSET_BITS-`ICACHE_IDX_BITS-1:0] icache_tag_t;

    typedef logic [`FETCH_LINE_BYTES*8-1:0] fetch_line_t;
    typedef logic [`FETCH_BEAT_WIDTH-1:0] grant_beat_t;
    typedef logic [$clog2(`FETCH_BEATS_PER_LINE)-1:0] beat_idx_t;

    // Cache miss handling
    typedef enum logic [1:0] {
        REFILL_IDLE,
        REFILL_ACQUIRE,
        REFILL_WAIT_LINE
    } refill_state_t;

    // Boot ROM line buffer
    typedef enum logic [1:0] {
        NC_IDLE,
        NC_REQUEST,
        NC_WAIT_LINE
    } nc_state_t;

endpackage

// File: hw/fetch_req_router.sv
`timescale 1ns/1ps
`include "fetch_consts.svh"

module fetch_req_router (
    input  logic                   clk_i,
    input  logic                   reset_i,
    input  logic                   fetch_req_i,
    input  fetch_pkg::paddr_t      fetch_addr_i,
    input  logic                   fetch_kill_i,
    input  logic                   done_i,
    output logic                   fetch_ready_o,
    output logic                   cache_req_o,
    output logic                   nc_req_o,
    output fetch_pkg::line_addr_t  req_line_o,
    output logic                   pending_kill_o
);

    logic busy_q;
    logic kill_q;
    logic accept;
    logic in_window;

    // Done frees the slot in the same cycle
    assign fetch_ready_o = ~busy_q | done_i;
    assign accept        = fetch_req_i & fetch_ready_o;

    assign in_window = fetch_addr_i[`FETCH_PADDR_WIDTH-1 -: `BROM_WINDOW_BITS] == `BROM_WINDOW_HI;
    assign req_line_o = fetch_addr_i[`FETCH_PADDR_WIDTH-1:`FETCH_OFFSET_BITS];

    assign cache_req_o = accept & ~in_window;
    assign nc_req_o    = accept & in_window;  // Boot ROM path

    // Kill seen this cycle counts at once
    assign pending_kill_o = busy_q & (kill_q | fetch_kill_i);

    // -----------------------------------------------------------------------
    // Outstanding request tracking
    // -----------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            busy_q <= 1'b0;
            kill_q <= 1'b0;
        end else if (accept) begin
            busy_q <= 1'b1;
            kill_q <= 1'b0;
        end else if (done_i) begin
            busy_q <= 1'b0;
            kill_q <= 1'b0;
        end else if (fetch_kill_i && busy_q) begin
            kill_q <= 1'b1;  // Sticky until done
        end
    end

endmodule

// File: hw/grant_collector.sv
`timescale 1ns/1ps
`include "fetch_consts.svh"

module grant_collector (
    input  logic                    clk_i,
    input  logic                    reset_i,
    input  logic                    l2_grant_valid_i,
    input  fetch_pkg::grant_beat_t  l2_grant_data_i,
    input  fetch_pkg::beat_idx_t    l2_grant_beat_i,
    input  logic                    l2_grant_inval_i,
    input  fetch_pkg::icache_idx_t  l2_grant_inval_idx_i,
    output logic                    line_valid_o,
    output fetch_pkg::fetch_line_t  line_o,
    output logic                    inval_o,
    output fetch_pkg::icache_idx_t  inval_idx_o
);

    fetch_pkg::grant_beat_t [`FETCH_BEATS_PER_LINE-1:0] beat_q;  // Beat 0 in the low word
    fetch_pkg::icache_idx_t inval_idx_q;
    logic data_beat;
    logic last_beat;
    logic line_valid_q;
    logic inval_q;

    assign data_beat = l2_grant_valid_i & ~l2_grant_inval_i;
    assign last_beat = l2_grant_beat_i == fetch_pkg::beat_idx_t'(`FETCH_BEATS_PER_LINE - 1);

    // Beat storage
    always_ff @(posedge clk_i) begin
        if (data_beat) begin
            beat_q[l2_grant_beat_i] <= l2_grant_data_i;
        end
        inval_idx_q <= l2_grant_inval_idx_i;
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            line_valid_q <= 1'b0;
            inval_q      <= 1'b0;
        end else begin
            line_valid_q <= data_beat & last_beat;
            inval_q      <= l2_grant_valid_i & l2_grant_inval_i;
        end
    end

    assign line_valid_o = line_valid_q;
    assign line_o       = beat_q;
    assign inval_o      = inval_q;
    assign inval_idx_o  = inval_idx_q;

endmodule

// File: hw/icache_lookup.sv
`timescale 1ns/1ps
`include "fetch_consts.svh"

module icache_lookup (
    input  logic                    clk_i,
    input  logic                    reset_i,
    input  logic                    flush_i,
    input  logic                    cache_req_i,
    input  fetch_pkg::line_addr_t   req_line_i,
    input  logic                    fill_i,
    input  fetch_pkg::fetch_line_t  fill_line_i,
    input  logic                    inval_i,
    input  fetch_pkg::icache_idx_t  inval_idx_i,
    output logic                    hit_o,
    output fetch_pkg::fetch_line_t  hit_data_o,
    output logic                    miss_o,
    output fetch_pkg::line_addr_t   miss_line_o
);

    fetch_pkg::icache_tag_t tag_mem [`ICACHE_NUM_SETS];
    fetch_pkg::fetch_line_t data_mem [`ICACHE_NUM_SETS];
    logic [`ICACHE_NUM_SETS-1:0] valid_q;

    fetch_pkg::icache_tag_t rd_tag_q;
    fetch_pkg::fetch_line_t rd_data_q;
    fetch_pkg::line_addr_t  line_q;
    logic                   req_q;

    fetch_pkg::icache_idx_t req_idx;
    fetch_pkg::icache_idx_t cur_idx;
    fetch_pkg::icache_tag_t cur_tag;
    logic                   tag_hit;

    assign req_idx = req_line_i[`ICACHE_IDX_BITS-1:0];
    assign cur_idx = line_q[`ICACHE_IDX_BITS-1:0];
    assign cur_tag = line_q[$bits(fetch_pkg::line_addr_t)-1:`ICACHE_IDX_BITS];

    // -----------------------------------------------------------------------
    // Compare stage one cycle after the request
    // -----------------------------------------------------------------------
    assign tag_hit = req_q & valid_q[cur_idx] & (rd_tag_q == cur_tag);

    // A fill returns the missed line as the response
    assign hit_o       = tag_hit | fill_i;
    assign hit_data_o  = fill_i ? fill_line_i : rd_data_q;
    assign miss_o      = req_q & ~tag_hit;
    assign miss_line_o = line_q;

    // Tag and data arrays
    always_ff @(posedge clk_i) begin
        if (cache_req_i) begin
            rd_tag_q  <= tag_mem[req_idx];
            rd_data_q <= data_mem[req_idx];
            line_q    <= req_line_i;  // Held through the refill
        end
        if (fill_i) begin
            tag_mem[cur_idx]  <= cur_tag;
            data_mem[cur_idx] <= fill_line_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            req_q   <= 1'b0;
            valid_q <= '0;
        end else begin
            req_q <= cache_req_i;
            if (fill_i) begin
                valid_q[cur_idx] <= 1'b1;
            end
            if (inval_i) begin
                valid_q[inval_idx_i] <= 1'b0;  // Wins over a fill
            end
            if (flush_i) begin
                valid_q <= '0;
            end
        end
    end

endmodule

// File: hw/icache_refill.sv
`timescale 1ns/1ps

module icache_refill (
    input  logic                    clk_i,
    input  logic                    reset_i,
    input  logic                    miss_i,
    input  fetch_pkg::line_addr_t   miss_line_i,
    input  logic                    line_valid_i,
    input  fetch_pkg::fetch_line_t  line_i,
    output logic                    acquire_valid_o,
    output fetch_pkg::line_addr_t   acquire_addr_o,
    output logic                    fill_o,
    output fetch_pkg::fetch_line_t  fill_line_o
);

    fetch_pkg::refill_state_t state_q;
    fetch_pkg::line_addr_t    addr_q;

    assign acquire_valid_o = state_q == fetch_pkg::REFILL_ACQUIRE;
    assign acquire_addr_o  = addr_q;

    // Fill goes out in the cycle the line is complete
    assign fill_o      = (state_q == fetch_pkg::REFILL_WAIT_LINE) & line_valid_i;
    assign fill_line_o = line_i;

    always_ff @(posedge clk_i) begin
        if (miss_i && state_q == fetch_pkg::REFILL_IDLE) begin
            addr_q <= miss_line_i;
        end
    end

    // -----------------------------------------------------------------------
    // Miss FSM
    // -----------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= fetch_pkg::REFILL_IDLE;
        end else begin
            case (state_q)
                fetch_pkg::REFILL_IDLE: begin
                    if (miss_i) begin
                        state_q <= fetch_pkg::REFILL_ACQUIRE;
                    end
                end
                fetch_pkg::REFILL_ACQUIRE: begin
                    state_q <= fetch_pkg::REFILL_WAIT_LINE;  // Single strobe
                end
                fetch_pkg::REFILL_WAIT_LINE: begin
                    if (line_valid_i) begin
                        state_q <= fetch_pkg::REFILL_IDLE;
                    end
                end
                default: begin
                    state_q <= fetch_pkg::REFILL_IDLE;
                end
            endcase
        end
    end

endmodule

// File: hw/nc_fetch_buffer.sv
`timescale 1ns/1ps

module nc_fetch_buffer (
    input  logic                    clk_i,
    input  logic                    reset_i,
    input  logic                    flush_i,
    input  logic                    nc_req_i,
    input  fetch_pkg::line_addr_t   req_line_i,
    input  logic                    line_valid_i,
    input  fetch_pkg::fetch_line_t  line_i,
    output logic                    brom_req_valid_o,
    output fetch_pkg::line_addr_t   brom_req_address_o,
    output logic                    resp_valid_o,
    output fetch_pkg::fetch_line_t  resp_data_o
);

    fetch_pkg::nc_state_t   state_q;
    fetch_pkg::line_addr_t  buf_addr_q;
    fetch_pkg::fetch_line_t buf_line_q;
    logic buf_valid_q;
    logic resp_q;
    logic hit;
    logic take_miss;
    logic line_done;

    assign hit       = buf_valid_q & ~flush_i & (buf_addr_q == req_line_i);
    assign take_miss = nc_req_i & ~hit & (state_q == fetch_pkg::NC_IDLE);
    assign line_done = line_valid_i & (state_q == fetch_pkg::NC_WAIT_LINE);

    assign brom_req_valid_o   = state_q == fetch_pkg::NC_REQUEST;
    assign brom_req_address_o = buf_addr_q;
    assign resp_valid_o       = resp_q;
    assign resp_data_o        = buf_line_q;  // Same register for a hit or a fresh line

    always_ff @(posedge clk_i) begin
        if (take_miss) begin
            buf_addr_q <= req_line_i;
        end
        if (line_done) begin
            buf_line_q <= line_i;
        end
    end

    // -----------------------------------------------------------------------
    // Buffer control
    // -----------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q     <= fetch_pkg::NC_IDLE;
            buf_valid_q <= 1'b0;
            resp_q      <= 1'b0;
        end else begin
            resp_q <= nc_req_i & hit;
            if (flush_i || take_miss) begin
                buf_valid_q <= 1'b0;
            end
            case (state_q)
                fetch_pkg::NC_IDLE: begin
                    if (take_miss) begin
                        state_q <= fetch_pkg::NC_REQUEST;
                    end
                end
                fetch_pkg::NC_REQUEST: begin
                    state_q <= fetch_pkg::NC_WAIT_LINE;
                end
                fetch_pkg::NC_WAIT_LINE: begin
                    if (line_valid_i) begin
                        buf_valid_q <= 1'b1;
                        resp_q      <= 1'b1;
                        state_q     <= fetch_pkg::NC_IDLE;
                    end
                end
                default: begin
                    state_q <= fetch_pkg::NC_IDLE;
                end
            endcase
        end
    end

endmodule

// File: hw/fetch_resp_merge.sv
`timescale 1ns/1ps

module fetch_resp_merge (
    input  logic                    clk_i,
    input  logic                    reset_i,
    input  logic                    cache_valid_i,
    input  fetch_pkg::fetch_line_t  cache_data_i,
    input  logic                    nc_valid_i,
    input  fetch_pkg::fetch_line_t  nc_data_i,
    input  logic                    pending_kill_i,
    output logic                    done_o,
    output logic                    fetch_resp_valid_o,
    output fetch_pkg::fetch_line_t  fetch_resp_data_o
);

    fetch_pkg::fetch_line_t data_q;
    logic any_valid;
    logic valid_q;
    logic done_q;

    assign any_valid = cache_valid_i | nc_valid_i;  // Never both at once

    always_ff @(posedge clk_i) begin
        if (any_valid) begin
            data_q <= nc_valid_i ? nc_data_i : cache_data_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_q <= 1'b0;
            done_q  <= 1'b0;
        end else begin
            valid_q <= any_valid & ~pending_kill_i;
            done_q  <= any_valid;  // Killed requests still complete
        end
    end

    assign done_o             = done_q;
    assign fetch_resp_valid_o = valid_q;
    assign fetch_resp_data_o  = data_q;

endmodule

// File: hw/fetch_tile.sv
`timescale 1ns/1ps

module fetch_tile (
    input  logic                    clk_i,
    input  logic                    reset_i,
    // Fetch source
    input  logic                    fetch_req_i,
    input  fetch_pkg::paddr_t       fetch_addr_i,
    input  logic                    fetch_kill_i,
    input  logic                    fetch_flush_i,
    output logic                    fetch_ready_o,
    output logic                    fetch_resp_valid_o,
    output fetch_pkg::fetch_line_t  fetch_resp_data_o,
    // L2 acquire and boot ROM request
    output logic                    io_mem_acquire_valid_o,
    output fetch_pkg::line_addr_t   io_mem_acquire_addr_o,
    output logic                    brom_req_valid_o,
    output fetch_pkg::line_addr_t   brom_req_address_o,
    // L2 grant
    input  logic                    l2_grant_valid_i,
    input  fetch_pkg::grant_beat_t  l2_grant_data_i,
    input  fetch_pkg::beat_idx_t    l2_grant_beat_i,
    input  logic                    l2_grant_inval_i,
    input  fetch_pkg::icache_idx_t  l2_grant_inval_idx_i
);

    logic cache_req;
    logic nc_req;
    logic pending_kill;
    logic done;
    fetch_pkg::line_addr_t req_line;

    logic line_valid;
    logic inval;
    fetch_pkg::fetch_line_t coll_line;
    fetch_pkg::icache_idx_t inval_idx;

    logic hit;
    logic miss;
    logic fill;
    fetch_pkg::fetch_line_t hit_data;
    fetch_pkg::fetch_line_t fill_line;
    fetch_pkg::line_addr_t  miss_line;

    logic nc_resp_valid;
    fetch_pkg::fetch_line_t nc_resp_data;

    // -----------------------------------------------------------------------
    // Input side
    // -----------------------------------------------------------------------
    fetch_req_router i_router (
        .clk_i, .reset_i, .fetch_req_i, .fetch_addr_i, .fetch_kill_i,
        .done_i(done), .fetch_ready_o, .cache_req_o(cache_req), .nc_req_o(nc_req),
        .req_line_o(req_line), .pending_kill_o(pending_kill)
    );

    grant_collector i_grant_collector (
        .clk_i, .reset_i, .l2_grant_valid_i, .l2_grant_data_i, .l2_grant_beat_i,
        .l2_grant_inval_i, .l2_grant_inval_idx_i, .line_valid_o(line_valid),
        .line_o(coll_line), .inval_o(inval), .inval_idx_o(inval_idx)
    );

    // Cache path
    icache_lookup i_icache_lookup (
        .clk_i, .reset_i, .flush_i(fetch_flush_i), .cache_req_i(cache_req),
        .req_line_i(req_line), .fill_i(fill), .fill_line_i(fill_line), .inval_i(inval),
        .inval_idx_i(inval_idx), .hit_o(hit), .hit_data_o(hit_data), .miss_o(miss),
        .miss_line_o(miss_line)
    );

    icache_refill i_icache_refill (
        .clk_i, .reset_i, .miss_i(miss), .miss_line_i(miss_line),
        .line_valid_i(line_valid), .line_i(coll_line),
        .acquire_valid_o(io_mem_acquire_valid_o), .acquire_addr_o(io_mem_acquire_addr_o),
        .fill_o(fill), .fill_line_o(fill_line)
    );

    // Boot ROM path
    nc_fetch_buffer i_nc_fetch_buffer (
        .clk_i, .reset_i, .flush_i(fetch_flush_i), .nc_req_i(nc_req),
        .req_line_i(req_line), .line_valid_i(line_valid), .line_i(coll_line),
        .brom_req_valid_o, .brom_req_address_o, .resp_valid_o(nc_resp_valid),
        .resp_data_o(nc_resp_data)
    );

    // -----------------------------------------------------------------------
    // Output side
    // -----------------------------------------------------------------------
    fetch_resp_merge i_resp_merge (
        .clk_i, .reset_i, .cache_valid_i(hit), .cache_data_i(hit_data),
        .nc_valid_i(nc_resp_valid), .nc_data_i(nc_resp_data),
        .pending_kill_i(pending_kill), .done_o(done), .fetch_resp_valid_o,
        .fetch_resp_data_o
    );

endmodule

// File: sim/tb_fetch_tile.sv
`timescale 1ns/1ps
`include "fetch_consts.svh"

module tb_fetch_tile;

    localparam int RANDOM_FETCHES = 200;
    localparam int NUM_PLANNED    = RANDOM_FETCHES + 40;  // Random plus directed
    localparam int WORST_CYCLES   = 24;                   // Miss with model latency plus margin

    logic clk;
    logic reset;
    logic fetch_req;
    fetch_pkg::paddr_t fetch_addr;
    logic fetch_kill;
    logic fetch_flush;
    logic fetch_ready;
    logic resp_valid;
    fetch_pkg::fetch_line_t resp_data;
    logic acq_valid;
    fetch_pkg::line_addr_t acq_addr;
    logic brom_valid;
    fetch_pkg::line_addr_t brom_addr;
    logic grant_valid;
    fetch_pkg::grant_beat_t grant_data;
    fetch_pkg::beat_idx_t grant_beat;
    logic grant_inval;
    fetch_pkg::icache_idx_t grant_inval_idx;

    // Memory model bookkeeping
    int acq_count;
    int brom_count;
    fetch_pkg::line_addr_t last_acq_line;
    fetch_pkg::line_addr_t last_brom_line;
    logic inval_pending;
    fetch_pkg::icache_idx_t inval_pending_idx;
    logic resp_expected;
    int seed;

    // Expected contents of the cache and the boot ROM buffer
    fetch_pkg::line_addr_t cached_line [`ICACHE_NUM_SETS];
    logic [`ICACHE_NUM_SETS-1:0] cached_valid;
    fetch_pkg::line_addr_t nc_line;
    logic nc_valid;

    fetch_tile i_fetch_tile (
        .clk_i(clk), .reset_i(reset), .fetch_req_i(fetch_req), .fetch_addr_i(fetch_addr),
        .fetch_kill_i(fetch_kill), .fetch_flush_i(fetch_flush), .fetch_ready_o(fetch_ready),
        .fetch_resp_valid_o(resp_valid), .fetch_resp_data_o(resp_data),
        .io_mem_acquire_valid_o(acq_valid), .io_mem_acquire_addr_o(acq_addr),
        .brom_req_valid_o(brom_valid), .brom_req_address_o(brom_addr),
        .l2_grant_valid_i(grant_valid), .l2_grant_data_i(grant_data),
        .l2_grant_beat_i(grant_beat), .l2_grant_inval_i(grant_inval),
        .l2_grant_inval_idx_i(grant_inval_idx)
    );

    initial begin : clock_gen
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic fail_mismatch(input string msg);
        $display("mismatch at %0t ns: %s", $time, msg);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic step();
        @(posedge clk);
        #2;  // Drive and sample away from the edge
    endtask

    // Beat word k of line L
    function automatic fetch_pkg::grant_beat_t line_word(fetch_pkg::line_addr_t line, int k);
        return {line, 2'(k), 2'b01} ^ 32'h3c5a_0000;
    endfunction

    function automatic fetch_pkg::fetch_line_t model_line(fetch_pkg::line_addr_t line);
        fetch_pkg::fetch_line_t data;
        for (int k = 0; k < 4; k++) begin
            data[32*k +: 32] = line_word(line, k);
        end
        return data;
    endfunction

    function automatic logic predict_miss(fetch_pkg::line_addr_t line, logic brom);
        fetch_pkg::icache_idx_t idx;
        idx = line[4:0];
        if (brom) begin
            return !(nc_valid && nc_line == line);
        end
        return !(cached_valid[idx] && cached_line[idx] == line);
    endfunction

    // ------------------------------------------------------------------------
    // Assertion on the response port
    // ------------------------------------------------------------------------
    assert property (@(posedge clk) resp_valid |-> resp_expected)
        else fail_mismatch("fetch response that was not expected");

    // Counts every cycle of an acquire or boot ROM request
    initial begin : request_monitor
        forever begin
            step();
            if (acq_valid) begin
                acq_count++;
                last_acq_line = acq_addr;
            end
            if (brom_valid) begin
                brom_count++;
                last_brom_line = brom_addr;
            end
        end
    end

    // L2 and boot ROM model that also sends queued invalidations
    initial begin : memory_model
        fetch_pkg::line_addr_t line;
        forever begin
            step();
            if (acq_valid || brom_valid) begin
                line = acq_valid ? acq_addr : brom_addr;
                repeat (3) step();  // Idle cycles before the grant
                for (int k = 0; k < 4; k++) begin
                    grant_valid = 1'b1;
                    grant_data  = line_word(line, k);
                    grant_beat  = 2'(k);
                    step();
                end
                grant_valid = 1'b0;
            end else if (inval_pending) begin
                grant_valid     = 1'b1;
                grant_inval     = 1'b1;
                grant_inval_idx = inval_pending_idx;
                step();
                grant_valid   = 1'b0;
                grant_inval   = 1'b0;
                inval_pending = 1'b0;
            end
        end
    end

    task automatic do_fetch(input fetch_pkg::paddr_t addr, input logic kill);
        fetch_pkg::line_addr_t line;
        logic brom;
        logic miss;
        int acq_before;
        int brom_before;
        int cycles;
        line        = addr[31:4];
        brom        = addr[31:16] == `BROM_WINDOW_HI;
        miss        = predict_miss(line, brom);
        acq_before  = acq_count;
        brom_before = brom_count;
        assert (fetch_ready) else fail_mismatch("fetch_ready_o low before a strobe");
        fetch_req     = 1'b1;
        fetch_addr    = addr;
        resp_expected = ~kill;
        step();
        fetch_req  = 1'b0;
        fetch_kill = kill;
        assert (!fetch_ready) else fail_mismatch("fetch_ready_o high after an accepted strobe");
        step();
        fetch_kill = 1'b0;
        cycles     = 2;
        if (kill) begin
            while (!fetch_ready) begin
                step();
            end
            assert (!resp_valid) else fail_mismatch("response for a killed fetch");
        end else begin
            while (!resp_valid) begin
                step();
                cycles++;
            end
            assert (resp_data == model_line(line))
                else fail_mismatch($sformatf("wrong data for line %h", line));
            assert (miss || cycles == 2)
                else fail_mismatch($sformatf("hit answered after %0d cycles", cycles));
            step();  // The response stays expected through its sampling edge
            resp_expected = 1'b0;
        end
        assert (acq_count - acq_before == ((miss && !brom) ? 1 : 0))
            else fail_mismatch($sformatf("acquire count wrong for line %h", line));
        assert (brom_count - brom_before == ((miss && brom) ? 1 : 0))
            else fail_mismatch($sformatf("boot ROM request count wrong for line %h", line));
        if (miss) begin
            assert ((brom ? last_brom_line : last_acq_line) == line)
                else fail_mismatch($sformatf("request address wrong for line %h", line));
            if (brom) begin
                nc_line  = line;
                nc_valid = 1'b1;
            end else begin
                cached_line[line[4:0]]  = line;
                cached_valid[line[4:0]] = 1'b1;
            end
        end
    endtask

    task automatic flush_all();
        fetch_flush = 1'b1;
        step();
        fetch_flush  = 1'b0;
        cached_valid = '0;
        nc_valid     = 1'b0;
    endtask

    task automatic send_inval(input fetch_pkg::paddr_t addr);
        inval_pending_idx = addr[8:4];
        inval_pending     = 1'b1;
        while (inval_pending) begin
            step();
        end
        step();  // Collector register stage
        cached_valid[addr[8:4]] = 1'b0;
    endtask

    initial begin : watchdog
        #(NUM_PLANNED * WORST_CYCLES * 20);
        $display("Timeout: the fetch sequence did not finish in time");
        $display("CHECKS FAILED");
        $fatal(1);
    end

    // ------------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------------
    initial begin : stimulus
        fetch_pkg::paddr_t addr;
        int r;
        seed            = 32'h0dba4932;
        reset           = 1'b1;
        fetch_req       = 1'b0;
        fetch_addr      = '0;
        fetch_kill      = 1'b0;
        fetch_flush     = 1'b0;
        grant_valid     = 1'b0;
        grant_data      = '0;
        grant_beat      = '0;
        grant_inval     = 1'b0;
        grant_inval_idx = '0;
        acq_count       = 0;
        brom_count      = 0;
        inval_pending   = 1'b0;
        resp_expected   = 1'b0;
        cached_valid    = '0;
        nc_valid        = 1'b0;
        repeat (8) @(posedge clk);
        #2 reset = 1'b0;
        assert (fetch_ready && !resp_valid && !acq_valid && !brom_valid)
            else fail_mismatch("outputs not in their reset state");

        do_fetch(32'h0000_1234, 1'b0);  // Miss then hit
        do_fetch(32'h0000_1238, 1'b0);
        do_fetch(32'h0001_0040, 1'b0);  // Boot ROM window
        do_fetch(32'h0001_004c, 1'b0);
        do_fetch(32'h0001_0080, 1'b0);
        do_fetch(32'h0000_2250, 1'b0);
        send_inval(32'h0000_1230);
        do_fetch(32'h0000_1230, 1'b0);
        do_fetch(32'h0000_2250, 1'b0);
        flush_all();
        do_fetch(32'h0000_1230, 1'b0);
        do_fetch(32'h0001_0080, 1'b0);
        do_fetch(32'h0000_3460, 1'b1);  // Killed miss still fills
        do_fetch(32'h0000_3460, 1'b0);

        for (int i = 0; i < RANDOM_FETCHES; i++) begin
            r = $random(seed);
            if (r[22:20] < 3'd2) begin
                addr = {`BROM_WINDOW_HI, 10'd0, r[5:4], r[3:0]};
            end else begin
                addr = {21'd0, r[13:12], 2'b00, r[8:6], r[3:0]};  // Conflicting indexes
            end
            do_fetch(addr, 1'b0);
        end

        repeat (4) step();
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// File: vlog.f
+incdir+hw
hw/fetch_pkg.sv
hw/fetch_req_router.sv
hw/grant_collector.sv
hw/icache_lookup.sv
hw/icache_refill.sv
hw/nc_fetch_buffer.sv
hw/fetch_resp_merge.sv
hw/fetch_tile.sv
sim/tb_fetch_tile.sv

// File: Makefile
obj_dir/Vtb_fetch_tile: vlog.f hw/fetch_consts.svh $(wildcard hw/*.sv sim/*.sv)
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module tb_fetch_tile -f vlog.f -o Vtb_fetch_tile

.PHONY: run clean

run: obj_dir/Vtb_fetch_tile
	@out="$$(./obj_dir/Vtb_fetch_tile)"; echo "$$out"; \
	echo "$$out" | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir
